//--- logic/aluCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module aluCore import aluPkg::*; (
	input  operandsT operands,
	output resultT   result
);

	logic [`DATA_W-1:0] a;
	logic [`DATA_W-1:0] b;

	// adder chain
	logic [4:0] nibSum;
	logic [3:0] carry;
	logic [`DATA_W-1:0] rawSum;
	logic [`DATA_W-1:0] satSum;
	logic [6:0] redAcc;
	logic [`DATA_W-1:0] redOut;
	logic [`DATA_W-1:0] adderOut;
	logic ovf;

	// shifter
	logic [3:0] amt;
	logic [2*`DATA_W-1:0] rotDbl;
	logic [`DATA_W-1:0] shiftOut;

	// output stage
	logic [`DATA_W-1:0] aluOut;
	logic [`DATA_W-1:0] res;
	logic isArith;
	logic noResult;

	assign a = operands.aluA;
	assign b = operands.aluB;

	// 4-bit lookahead group
	function automatic logic [4:0] cla4(input logic [3:0] x, input logic [3:0] y,
		input logic cIn);
		logic [3:0] g;
		logic [3:0] p;
		logic [4:0] c;
		g = x & y;
		p = x ^ y;
		c[0] = cIn;
		c[1] = g[0] | (p[0] & c[0]);
		c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
		c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & c[0]);
		c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0])
			| (p[3] & p[2] & p[1] & p[0] & c[0]);
		return {c[4], p ^ c[3:0]};
	endfunction

	////////////////////
	// adder
	////////////////////

	always_comb begin
		// carry-in of one completes the subtract
		carry[0] = operands.aluOp.sub;
		rawSum = '0;
		for (int i = 0; i < 4; i++) begin
			nibSum = cla4(a[4*i +: 4], b[4*i +: 4], carry[i]);
			rawSum[4*i +: 4] = nibSum[3:0];
			// paired-byte mode breaks the chain between bytes
			if (i < 3) begin
				carry[i+1] = nibSum[4] & ~(operands.aluOp.sat && i == 1);
			end
		end
	end

	// clamp each byte to the signed byte range
	always_comb begin
		satSum = rawSum;
		for (int k = 0; k < 2; k++) begin
			if (!a[8*k+7] && !b[8*k+7] && rawSum[8*k+7]) begin
				satSum[8*k +: 8] = 8'h7f;
			end else if (a[8*k+7] && b[8*k+7] && !rawSum[8*k+7]) begin
				satSum[8*k +: 8] = 8'h80;
			end
		end
	end

	// sum of all eight signed nibbles
	always_comb begin
		redAcc = '0;
		for (int i = 0; i < 4; i++) begin
			redAcc = redAcc + {{3{a[4*i+3]}}, a[4*i +: 4]} + {{3{b[4*i+3]}}, b[4*i +: 4]};
		end
	end

	assign redOut = {{(`DATA_W-7){redAcc[6]}}, redAcc};

	assign adderOut = operands.aluOp.red ? redOut :
		operands.aluOp.sat ? satSum : rawSum;

	// same operand signs but sum sign flipped
	assign ovf = (a[15] == b[15]) && (rawSum[15] != a[15]);

	////////////////////
	// shifter
	////////////////////

	assign amt = b[3:0];
	assign rotDbl = {a, a} >> amt;

	always_comb begin
		case (operands.aluOp.shiftOp)
			2'd0: shiftOut = a << amt;
			2'd1: shiftOut = $signed(a) >>> amt;
			2'd2: shiftOut = rotDbl[`DATA_W-1:0];
			default: shiftOut = a;
		endcase
	end

	////////////////////
	// output and flags
	////////////////////

	always_comb begin
		case (operands.aluOp.outSel)
			selAdder: aluOut = adderOut;
			selXor: aluOut = a ^ b;
			selShift: aluOut = shiftOut;
			default: aluOut = '0;
		endcase
	end

	assign noResult = (operands.opcode == opB) || (operands.opcode == opBr) ||
		(operands.opcode == opHlt);
	assign isArith = (operands.opcode == opAdd) || (operands.opcode == opSub);

	// branches and halt have nothing to compute
	assign res = noResult ? '0 : aluOut;

	assign result.value = res;
	assign result.zeroFlag = (res == '0);
	assign result.negFlag = isArith & res[15];
	assign result.ovfFlag = isArith & ovf;
	assign result.opcode = operands.opcode;

	// decoder in operandFormat never emits the spare select
	always_comb begin
		outSelLegal: assert final (operands.aluOp.outSel !== selNone);
	end

endmodule

`default_nettype wire

//--- logic/aluExecTop.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module aluExecTop import aluPkg::*; (
	input  logic               clk,
	input  logic               rstN,
	input  logic               inValid,
	output logic               inReady,
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] regData1,
	input  logic [`DATA_W-1:0] regData2,
	input  logic [`DATA_W-1:0] pcs,
	input  logic               ldByte,
	input  logic               memOp,
	input  logic [`DATA_W-1:0] aluOutMem,
	input  logic [`DATA_W-1:0] writeData,
	input  logic [1:0]         forwardA,
	input  logic [1:0]         forwardB,
	output logic               outValid,
	input  logic               outReady,
	output logic [`DATA_W-1:0] result,
	output logic               zeroFlag,
	output logic               negFlag,
	output logic               ovfFlag,
	output opcodeT             outOpcode
);

	operandsT fmtOperands;
	operandsT headOperands;
	resultT aluResult;
	resultT headResult;
	logic opValid;
	logic resReady;

	// combinational operand build
	operandFormat format_i (
		.instr(instr), .regData1(regData1), .regData2(regData2), .pcs(pcs),
		.ldByte(ldByte), .memOp(memOp), .aluOutMem(aluOutMem), .writeData(writeData),
		.forwardA(forwardA), .forwardB(forwardB), .operands(fmtOperands)
	);

	stageFifo #(.payloadT(operandsT), .depth(`FIFO_DEPTH)) opFifo_i (
		.clk(clk), .rstN(rstN),
		.wrValid(inValid), .wrData(fmtOperands), .wrReady(inReady),
		.rdValid(opValid), .rdReady(resReady), .rdData(headOperands)
	);

	// executes on the operand buffer head
	aluCore alu_i (.operands(headOperands), .result(aluResult));

	// holds results while the next stage stalls
	stageFifo #(.payloadT(resultT), .depth(`FIFO_DEPTH)) resFifo_i (
		.clk(clk), .rstN(rstN),
		.wrValid(opValid), .wrData(aluResult), .wrReady(resReady),
		.rdValid(outValid), .rdReady(outReady), .rdData(headResult)
	);

	assign result = headResult.value;
	assign zeroFlag = headResult.zeroFlag;
	assign negFlag = headResult.negFlag;
	assign ovfFlag = headResult.ovfFlag;
	assign outOpcode = headResult.opcode;

endmodule

`default_nettype wire

//--- logic/aluPkg.sv
`default_nettype none

`include "alu_consts.svh"

package aluPkg;

	// instruction opcodes, upper nibble of instr
	typedef enum logic [3:0] {
		opAdd    = `OP_ADD,
		opSub    = `OP_SUB,
		opRed    = `OP_RED,
		opXor    = `OP_XOR,
		opSll    = `OP_SLL,
		opSra    = `OP_SRA,
		opRor    = `OP_ROR,
		opPaddsb = `OP_PADDSB,
		opLw     = `OP_LW,
		opSw     = `OP_SW,
		opLhb    = `OP_LHB,
		opLlb    = `OP_LLB,
		opB      = `OP_B,
		opBr     = `OP_BR,
		opPcs    = `OP_PCS,
		opHlt    = `OP_HLT
	} opcodeT;

	// which functional unit drives the ALU output
	typedef enum logic [1:0] {
		selAdder = 2'd0,
		selXor   = 2'd1,
		selShift = 2'd2,
		selNone  = 2'd3
	} outSelT;

	// 7-bit operation word sent to the ALU
	typedef struct packed {
		outSelT     outSel;
		logic       sat;
		logic       red;
		logic       sub;
		logic [1:0] shiftOp;
	} aluOpT;

	// formatted operands, payload of the first buffer
	typedef struct packed {
		logic [`DATA_W-1:0] aluA;
		logic [`DATA_W-1:0] aluB;
		aluOpT              aluOp;
		opcodeT             opcode;
	} operandsT;

	// ALU result and flags, payload of the second buffer
	typedef struct packed {
		logic [`DATA_W-1:0] value;
		logic               zeroFlag;
		logic               negFlag;
		logic               ovfFlag;
		opcodeT             opcode;
	} resultT;

endpackage

`default_nettype wire

//--- logic/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// datapath width, one machine word
`define DATA_W 16

// entries held by each stage buffer
`define FIFO_DEPTH 2

// opcode values as found in instr[15:12]
`define OP_ADD    4'h0
`define OP_SUB    4'h1
`define OP_RED    4'h2
`define OP_XOR    4'h3
`define OP_SLL    4'h4
`define OP_SRA    4'h5
`define OP_ROR    4'h6
`define OP_PADDSB 4'h7
`define OP_LW     4'h8
`define OP_SW     4'h9
`define OP_LHB    4'ha
`define OP_LLB    4'hb
`define OP_B      4'hc
`define OP_BR     4'hd
`define OP_PCS    4'he
`define OP_HLT    4'hf

`endif

//--- logic/operandFormat.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module operandFormat import aluPkg::*; (
	input  logic [`DATA_W-1:0] instr,
	input  logic [`DATA_W-1:0] regData1,
	input  logic [`DATA_W-1:0] regData2,
	input  logic [`DATA_W-1:0] pcs,
	input  logic               ldByte,
	input  logic               memOp,
	input  logic [`DATA_W-1:0] aluOutMem,
	input  logic [`DATA_W-1:0] writeData,
	input  logic [1:0]         forwardA,
	input  logic [1:0]         forwardB,
	output operandsT           operands
);

	opcodeT opcode;
	aluOpT aluOp;

	// decoded control
	logic useImm;
	logic byteSel;
	logic pcsSel;

	// datapath intermediates
	logic [`DATA_W-1:0] regA;
	logic [`DATA_W-1:0] regB;
	logic [`DATA_W-1:0] byteA;
	logic [`DATA_W-1:0] byteB;
	logic [`DATA_W-1:0] immMem;
	logic [`DATA_W-1:0] imm;
	logic [`DATA_W-1:0] operandA;
	logic [`DATA_W-1:0] operandB;

	assign opcode = opcodeT'(instr[15:12]);

	////////////////////
	// opcode decode
	////////////////////

	always_comb begin
		// adder path unless told otherwise
		aluOp.outSel = selAdder;
		aluOp.sat = 1'b0;
		aluOp.red = 1'b0;
		aluOp.sub = 1'b0;
		// shift kind sits in the low opcode bits
		aluOp.shiftOp = instr[13:12];
		useImm = 1'b0;
		pcsSel = 1'b0;
		case (opcode)
			opSub: aluOp.sub = 1'b1;
			opRed: aluOp.red = 1'b1;
			opXor: aluOp.outSel = selXor;
			opPaddsb: aluOp.sat = 1'b1;
			opSll, opSra, opRor: begin
				aluOp.outSel = selShift;
				useImm = 1'b1;
			end
			// address or byte immediate goes through the adder
			opLw, opSw, opLhb, opLlb: useImm = 1'b1;
			opPcs: pcsSel = 1'b1;
			default: ;
		endcase
	end

	// high for llb, low for lhb
	assign byteSel = instr[12];

	////////////////////
	// A operand
	////////////////////

	// mem stage result wins over writeback
	assign regA = forwardA[1] ? aluOutMem :
		forwardA[0] ? writeData : regData1;

	// clear the byte that the load will replace
	assign byteA = byteSel ? {regA[15:8], 8'h00} : {8'h00, regA[7:0]};

	assign operandA = ldByte ? byteA : regA;

	////////////////////
	// B operand
	////////////////////

	assign regB = forwardB[1] ? aluOutMem :
		forwardB[0] ? writeData : regData2;

	// 8-bit immediate lands in the byte A left open
	assign byteB = byteSel ? {8'h00, instr[7:0]} : {instr[7:0], 8'h00};

	// word offset for memory ops, raw amount for shifts
	assign immMem = memOp ? {{11{instr[3]}}, instr[3:0], 1'b0} : {12'h000, instr[3:0]};

	assign imm = ldByte ? byteB : immMem;

	// sub uses ones complement here, carry-in comes from the adder
	assign operandB = useImm ? imm : (aluOp.sub ? ~regB : regB);

	// pcs computes 0 + pc through the adder
	assign operands.aluA = pcsSel ? '0 : operandA;
	assign operands.aluB = pcsSel ? pcs : operandB;
	assign operands.aluOp = aluOp;
	assign operands.opcode = opcode;

endmodule

`default_nettype wire

//--- logic/stageFifo.sv
`timescale 1ns/100ps
`default_nettype none

module stageFifo #(
	parameter type payloadT = logic,
	parameter int  depth    = 2
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    wrValid,
	input  payloadT wrData,
	output logic    wrReady,
	output logic    rdValid,
	input  logic    rdReady,
	output payloadT rdData
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntW = $clog2(depth + 1);

	// payload storage
	payloadT mem [depth];

	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [cntW-1:0] count;
	logic wrFire;
	logic rdFire;

	// full blocks writes even if a read happens this cycle
	assign wrReady = (count != cntW'(depth));
	assign rdValid = (count != '0);
	assign wrFire = wrValid && wrReady;
	assign rdFire = rdValid && rdReady;

	// head entry
	assign rdData = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (wrFire) begin
			mem[wrPtr] <= wrData;
		end
	end

	////////////////////
	// pointers and count
	////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (wrFire) begin
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (rdFire) begin
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
			end
			// both at once leaves the count unchanged
			if (wrFire && !rdFire) begin
				count <= count + 1'b1;
			end else if (rdFire && !wrFire) begin
				count <= count - 1'b1;
			end
		end
	end

	// occupancy stays within the buffer
	countBound: assert property (@(posedge clk) disable iff (!rstN)
		count <= cntW'(depth));

	// a stalled head keeps its data and its valid
	headStable: assert property (@(posedge clk) disable iff (!rstN)
		(rdValid && !rdReady) |=> (rdValid && $stable(rdData)));

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/aluPkg.sv
logic/operandFormat.sv
logic/stageFifo.sv
logic/aluCore.sv
logic/aluExecTop.sv
verification/tbAluExec.sv

//--- verification/tbAluExec.sv
`timescale 1ns/100ps
`default_nettype none

`include "alu_consts.svh"

module tbAluExec import aluPkg::*; ();

	localparam int waitLimit = 200;

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	logic outValid;
	logic outReady;
	logic ldByte;
	logic memOp;
	logic [`DATA_W-1:0] instr;
	logic [`DATA_W-1:0] regData1;
	logic [`DATA_W-1:0] regData2;
	logic [`DATA_W-1:0] pcs;
	logic [`DATA_W-1:0] aluOutMem;
	logic [`DATA_W-1:0] writeData;
	logic [1:0] forwardA;
	logic [1:0] forwardB;
	logic [`DATA_W-1:0] result;
	logic zeroFlag;
	logic negFlag;
	logic ovfFlag;
	opcodeT outOpcode;

	// scoreboard state
	resultT expQ[$];
	resultT expHead;
	logic expAvail = 1'b0;
	logic randomReady = 1'b0;
	int inFlight = 0;
	int maxInFlight = 0;
	int inCount = 0;
	int outCount = 0;
	int errCount = 0;
	int testCount = 0;

	aluExecTop dut_i (
		.clk(clk), .rstN(rstN), .inValid(inValid), .inReady(inReady),
		.instr(instr), .regData1(regData1), .regData2(regData2), .pcs(pcs),
		.ldByte(ldByte), .memOp(memOp), .aluOutMem(aluOutMem), .writeData(writeData),
		.forwardA(forwardA), .forwardB(forwardB), .outValid(outValid), .outReady(outReady),
		.result(result), .zeroFlag(zeroFlag), .negFlag(negFlag), .ovfFlag(ovfFlag),
		.outOpcode(outOpcode)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////
	// reference model
	////////////////////

	function automatic resultT refModel(input logic [15:0] ins, input logic [15:0] r1,
		input logic [15:0] r2, input logic [15:0] pcVal, input logic [15:0] memVal,
		input logic [15:0] wbVal, input logic [1:0] fa, input logic [1:0] fb);
		resultT r;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] val;
		logic [3:0] amt;
		logic signed [31:0] acc;
		logic signed [15:0] offset;
		// mem stage forward has priority
		a = fa[1] ? memVal : (fa[0] ? wbVal : r1);
		b = fb[1] ? memVal : (fb[0] ? wbVal : r2);
		amt = ins[3:0];
		val = '0;
		r = '0;
		case (ins[15:12])
			`OP_ADD: val = a + b;
			`OP_SUB: val = a - b;
			`OP_RED: begin
				acc = 0;
				for (int i = 0; i < 4; i++) begin
					acc = acc + $signed(a[4*i +: 4]) + $signed(b[4*i +: 4]);
				end
				val = acc[15:0];
			end
			`OP_XOR: val = a ^ b;
			`OP_SLL: val = a << amt;
			`OP_SRA: val = $signed(a) >>> amt;
			`OP_ROR: val = (a >> amt) | (a << (5'd16 - amt));
			`OP_PADDSB: begin
				// each byte clamped to -128..127
				for (int k = 0; k < 2; k++) begin
					acc = $signed(a[8*k +: 8]) + $signed(b[8*k +: 8]);
					if (acc > 127) begin
						acc = 127;
					end else if (acc < -128) begin
						acc = -128;
					end
					val[8*k +: 8] = acc[7:0];
				end
			end
			`OP_LW, `OP_SW: begin
				// signed word offset scaled to bytes
				offset = $signed(ins[3:0]) * 2;
				val = a + offset;
			end
			`OP_LHB: val = {ins[7:0], a[7:0]};
			`OP_LLB: val = {a[15:8], ins[7:0]};
			`OP_PCS: val = pcVal;
			default: val = '0;
		endcase
		r.value = val;
		r.zeroFlag = (val == '0);
		r.opcode = opcodeT'(ins[15:12]);
		// flags beyond zero only for add and sub
		if (ins[15:12] == `OP_ADD) begin
			r.negFlag = val[15];
			r.ovfFlag = (a[15] == b[15]) && (val[15] != a[15]);
		end else if (ins[15:12] == `OP_SUB) begin
			r.negFlag = val[15];
			r.ovfFlag = (a[15] != b[15]) && (val[15] != a[15]);
		end
		return r;
	endfunction

	////////////////////
	// monitor and checks
	////////////////////

	// pop before push so a same-edge in and out stay ordered
	always @(posedge clk) begin
		if (!rstN) begin
			expQ.delete();
			inFlight = 0;
		end else begin
			if (outValid && outReady) begin
				if (expQ.size() > 0) begin
					void'(expQ.pop_front());
				end
				outCount++;
				inFlight--;
			end
			if (inValid && inReady) begin
				expQ.push_back(refModel(instr, regData1, regData2, pcs, aluOutMem,
					writeData, forwardA, forwardB));
				inCount++;
				inFlight++;
			end
			if (inFlight > maxInFlight) begin
				maxInFlight = inFlight;
			end
		end
		expAvail = (expQ.size() > 0);
		expHead = expAvail ? expQ[0] : '0;
	end

	// every output transfer against the oldest expected result
	outMatch: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && outReady) |-> (expAvail && result == expHead.value &&
		zeroFlag == expHead.zeroFlag && negFlag == expHead.negFlag &&
		ovfFlag == expHead.ovfFlag && outOpcode == expHead.opcode))
		else begin
			errCount++;
			if (!$sampled(expAvail)) begin
				$display("an output was delivered with no input pending at %0t", $time);
			end else begin
				$display("** Error at %0t: op %h got %h znv %b%b%b, expected %h znv %b%b%b",
					$time, $sampled(expHead.opcode), $sampled(result), $sampled(zeroFlag),
					$sampled(negFlag), $sampled(ovfFlag), $sampled(expHead.value),
					$sampled(expHead.zeroFlag), $sampled(expHead.negFlag),
					$sampled(expHead.ovfFlag));
			end
		end

	// stall only when both buffers are full
	inFlightBound: assert property (@(posedge clk) disable iff (!rstN)
		(inFlight <= 2*`FIFO_DEPTH) && (inFlight >= `FIFO_DEPTH || inReady) &&
		(inFlight != 2*`FIFO_DEPTH || !inReady))
		else begin
			errCount++;
			$display("inReady disagrees with %0d items in flight at %0t", $sampled(inFlight), $time);
		end

	// idle pipeline gives a two cycle latency
	latencyTwo: assert property (@(posedge clk) disable iff (!rstN)
		(inValid && inReady && inFlight == 0) |-> ##1 !outValid ##1 outValid)
		else begin
			errCount++;
			$display("an input into the idle pipeline missed its 2 cycle output at %0t", $time);
		end

	////////////////////
	// stimulus helpers
	////////////////////

	task automatic abortRun(input string what);
		$display("timeout while waiting for %0s at %0t", what, $time);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	// one falling edge with optional random consumer stalls
	task automatic tick();
		@(negedge clk);
		if (randomReady) begin
			outReady = ($urandom_range(0, 2) != 0);
		end
	endtask

	task automatic sendItem(input logic [15:0] ins, input logic [15:0] r1,
		input logic [15:0] r2, input logic [15:0] pcVal, input logic [15:0] memVal,
		input logic [15:0] wbVal, input logic [1:0] fa, input logic [1:0] fb);
		int waited;
		instr = ins;
		regData1 = r1;
		regData2 = r2;
		pcs = pcVal;
		aluOutMem = memVal;
		writeData = wbVal;
		forwardA = fa;
		forwardB = fb;
		// upstream decode flags
		ldByte = (ins[15:12] == `OP_LHB) || (ins[15:12] == `OP_LLB);
		memOp = (ins[15:12] == `OP_LW) || (ins[15:12] == `OP_SW);
		inValid = 1'b1;
		waited = 0;
		while (!inReady) begin
			if (waited >= waitLimit) begin
				abortRun("inReady");
			end
			tick();
			waited++;
		end
		// accepted on the rising edge inside this tick
		tick();
		inValid = 1'b0;
	endtask

	task automatic sendRandom(input logic [3:0] op);
		sendItem({op, 12'($urandom())}, 16'($urandom()), 16'($urandom()), 16'($urandom()),
			16'($urandom()), 16'($urandom()), 2'($urandom()), 2'($urandom()));
	endtask

	task automatic waitIdle();
		int waited;
		waited = 0;
		while (inFlight != 0) begin
			if (waited >= waitLimit) begin
				abortRun("the pipeline to drain");
			end
			tick();
			waited++;
		end
	endtask

	task automatic reportTest(input string name, input int errStart);
		testCount++;
		$display("test %0s done with %0d errors", name, errCount - errStart);
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		int errStart;
		int k;
		logic [3:0] op;
		void'($urandom(32'he91e3d0e));
		rstN = 1'b0;
		inValid = 1'b0;
		outReady = 1'b1;
		instr = '0;
		regData1 = '0;
		regData2 = '0;
		pcs = '0;
		aluOutMem = '0;
		writeData = '0;
		forwardA = '0;
		forwardB = '0;
		ldByte = 1'b0;
		memOp = 1'b0;
		repeat (5) @(negedge clk);
		rstN = 1'b1;

		// reset state and then one item through the idle pipeline
		errStart = errCount;
		assert (!outValid && inReady) else begin
			errCount++;
			$display("outValid high or inReady low right after reset");
		end
		sendRandom(`OP_ADD);
		waitIdle();
		reportTest("reset", errStart);

		errStart = errCount;
		// byte limits of paddsb and word overflow of add and sub
		sendItem({`OP_PADDSB, 12'h0}, 16'h7f7f, 16'h0101, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		sendItem({`OP_PADDSB, 12'h0}, 16'h8080, 16'hffff, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		sendItem({`OP_PADDSB, 12'h0}, 16'h7f80, 16'h01ff, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		sendItem({`OP_ADD, 12'h0}, 16'h7fff, 16'h0001, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		sendItem({`OP_SUB, 12'h0}, 16'h8000, 16'h0001, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		sendItem({`OP_SUB, 12'h0}, 16'h1234, 16'h1234, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		sendItem({`OP_RED, 12'h0}, 16'h8888, 16'h8888, 16'h0, 16'h0, 16'h0, 2'd0, 2'd0);
		repeat (60) begin
			case ($urandom_range(0, 4))
				0: op = `OP_ADD;
				1: op = `OP_SUB;
				2: op = `OP_XOR;
				3: op = `OP_PADDSB;
				default: op = `OP_RED;
			endcase
			sendRandom(op);
		end
		waitIdle();
		reportTest("arithmetic", errStart);

		// every amount for each shift kind
		errStart = errCount;
		for (op = `OP_SLL; op <= `OP_ROR; op++) begin
			for (k = 0; k < 16; k++) begin
				sendItem({op, 8'($urandom()), 4'(k)}, 16'($urandom()), 16'($urandom()),
					16'h0, 16'($urandom()), 16'($urandom()), 2'($urandom()), 2'd0);
			end
		end
		waitIdle();
		reportTest("shifts", errStart);

		errStart = errCount;
		for (k = 0; k < 16; k++) begin
			sendItem({`OP_LW, 8'($urandom()), 4'(k)}, 16'($urandom()), 16'($urandom()),
				16'h0, 16'($urandom()), 16'($urandom()), 2'($urandom()), 2'd0);
		end
		repeat (12) begin
			sendRandom(`OP_SW);
			sendRandom(`OP_LHB);
			sendRandom(`OP_LLB);
		end
		waitIdle();
		reportTest("immediates", errStart);

		// all select pairs with distinct data on each source
		errStart = errCount;
		for (k = 0; k < 16; k++) begin
			sendItem({`OP_XOR, 12'h0}, 16'h1111, 16'h2222, 16'h0, 16'h4444, 16'h8888,
				2'(k >> 2), 2'(k));
			sendRandom(`OP_SUB);
		end
		repeat (8) sendRandom(`OP_PCS);
		waitIdle();
		reportTest("forwarding", errStart);

		// fill both buffers with the consumer stalled
		errStart = errCount;
		outReady = 1'b0;
		repeat (4) sendRandom(`OP_ADD);
		assert (!inReady && inFlight == 4) else begin
			errCount++;
			$display("pipeline did not stall with four items in flight");
		end
		randomReady = 1'b1;
		repeat (60) begin
			k = $urandom_range(0, 12);
			op = (k == 12) ? `OP_PCS : 4'(k);
			sendRandom(op);
		end
		waitIdle();
		randomReady = 1'b0;
		outReady = 1'b1;
		assert (maxInFlight == 4) else begin
			errCount++;
			$display("never reached four items in flight");
		end
		reportTest("backpressure", errStart);

		// nothing lost or duplicated over the whole run
		assert (expQ.size() == 0 && inCount == outCount) else begin
			errCount++;
			$display("%0d inputs but %0d outputs", inCount, outCount);
		end
		$display("tests %0d, inputs %0d, outputs %0d, errors %0d",
			testCount, inCount, outCount, errCount);
		if (errCount == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
